// ==== all.f ====
+incdir+verif
src/m92_bus_pkg.sv
src/m92_io_pkg.sv
src/m92_bus_decode.sv
src/m92_rom_fetch.sv
src/m92_io_regs.sv
src/m92_work_ram.sv
src/m92_read_mux.sv
src/m92_cpu_bus.sv
verif/m92_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bus controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -j 0 -f all.f --top-module m92_tb -o m92_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/m92_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== src/m92_bus_decode.sv ====
/*
  V33 bus cycle and region decode with ROM address translation.
  rom_start is a single-cycle pulse in the cycle where n_bcyst falls
  during a ROM memory read.
*/
`timescale 1ns/10ps

module m92_bus_decode
    import m92_bus_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset_n,
    input  cpu_status_t status,
    input  logic [3:0]  bank,
    output bus_req_t    req,
    output logic        rom_start
);

    logic        n_bcyst_prev;
    logic        rom_read;
    logic [19:0] word_addr;

    assign word_addr = {status.addr[19:1], 1'b0};

    always_comb begin
        // Cycle kind from the status pins
        if (!status.m_io && !status.r_w && !status.busst1 && status.busst0 && !status.n_dstb) begin
            req.cycle = cyc_io_write;
        end else if (!status.m_io && status.r_w && !status.busst1 && status.busst0) begin
            req.cycle = cyc_io_read;
        end else if (status.m_io && !status.r_w && !status.busst1 && status.busst0
                     && !status.n_dstb) begin
            req.cycle = cyc_mem_write;
        end else if (status.m_io && status.r_w && !status.busst1) begin
            req.cycle = cyc_mem_read;
        end else begin
            req.cycle = cyc_idle;
        end

        req.rom_addr = {4'h0, word_addr};
        if (status.addr <= ROM_FIXED_END) begin
            req.region = rgn_rom_fixed;
        end else if (status.addr >= ROM_BANK_BASE && status.addr <= ROM_BANK_END) begin
            req.region   = rgn_rom_banked;
            req.rom_addr = ROM_BANK_OFFSET + {4'h0, bank, status.addr[15:1], 1'b0};
        end else if (status.addr >= RAM_BASE && status.addr <= RAM_END) begin
            req.region = rgn_work_ram;
        end else if (word_addr == VID_CTRL_ADDR) begin
            req.region = rgn_video_ctrl;
        end else begin
            req.region = rgn_unmapped;
        end

        req.addr  = status.addr;
        req.lanes = {~status.n_ube, ~status.addr[0]};
    end

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            n_bcyst_prev <= 1'b1;
        end else begin
            n_bcyst_prev <= status.n_bcyst;
        end
    end

    assign rom_read  = (req.cycle == cyc_mem_read)
                     && (req.region == rgn_rom_fixed || req.region == rgn_rom_banked);
    assign rom_start = rom_read && !status.n_bcyst && n_bcyst_prev;   // Falling edge only

endmodule

// ==== src/m92_bus_pkg.sv ====
/*
  Bus cycle and memory region types for the main CPU bus controller.
  Addresses are V33 20-bit byte addresses; external ROM addresses are 24-bit.
*/
package m92_bus_pkg;

    // ============================================================
    // Address map
    // ============================================================
    localparam int ROM_ADDR_W = 24;

    localparam logic [19:0] ROM_FIXED_END = 20'h9FFFF;   // Last fixed ROM byte
    localparam logic [19:0] ROM_BANK_BASE = 20'hA0000;
    localparam logic [19:0] ROM_BANK_END  = 20'hAFFFF;
    localparam logic [ROM_ADDR_W-1:0] ROM_BANK_OFFSET = 24'h100000; // Bank 0 in ROM space
    localparam logic [19:0] RAM_BASE      = 20'hE0000;
    localparam logic [19:0] RAM_END       = 20'hEFFFF;
    localparam logic [19:0] VID_CTRL_ADDR = 20'hF9800;

    // ============================================================
    // Types
    // ============================================================
    typedef enum logic [2:0] {
        cyc_idle,
        cyc_io_read,
        cyc_io_write,
        cyc_mem_read,
        cyc_mem_write
    } bus_cycle_e;

    typedef enum logic [2:0] {
        rgn_rom_fixed,
        rgn_rom_banked,
        rgn_work_ram,
        rgn_video_ctrl,
        rgn_unmapped
    } mem_region_e;

    // Raw V33 status pins
    typedef struct packed {
        logic        m_io;
        logic        r_w;
        logic        busst0;
        logic        busst1;
        logic        n_dstb;
        logic        n_bcyst;
        logic        n_ube;
        logic [19:0] addr;
    } cpu_status_t;

    typedef struct packed {
        bus_cycle_e            cycle;
        mem_region_e           region;
        logic [19:0]           addr;
        logic [1:0]            lanes;    // {high, low}
        logic [ROM_ADDR_W-1:0] rom_addr;
    } bus_req_t;

endpackage

// ==== src/m92_cpu_bus.sv ====
/*
  Main CPU bus controller top level.
  The CPU core sits outside; ROM lives behind an AXI4-Lite read port.
*/
`timescale 1ns/10ps

module m92_cpu_bus
    import m92_bus_pkg::*;
    import m92_io_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset_n,
    input  cpu_status_t           status,
    input  logic [15:0]           cpu_dout,
    output logic [15:0]           cpu_din,
    output logic                  n_ready,
    input  player_in_t            players,
    input  logic                  kick_harness,
    output logic [ROM_ADDR_W-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [15:0]           rdata,
    input  logic [1:0]            rresp,
    input  logic                  rvalid,
    output logic                  rready,
    output sys_ctrl_t             sys_ctrl,
    output logic                  flip,
    output logic [15:0]           vid_ctrl
);

    bus_req_t    req;
    logic        rom_start;
    logic        rom_busy;
    logic [3:0]  bank;
    logic [15:0] rom_data;
    logic [15:0] ram_data;
    logic [15:0] io_data;

    // ============================================================
    // Decode, execute, result
    // ============================================================
    m92_bus_decode u_decode (
        .clk_sys, .reset_n, .status, .bank, .req, .rom_start
    );

    m92_rom_fetch u_rom_fetch (
        .clk_sys, .reset_n, .rom_start, .req,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .rom_data, .busy(rom_busy)
    );

    m92_io_regs u_io_regs (
        .clk_sys, .reset_n, .req, .cpu_dout, .players, .kick_harness,
        .io_data, .sys_ctrl, .bank, .flip, .vid_ctrl
    );

    m92_work_ram u_work_ram (.clk_sys, .req, .cpu_dout, .ram_data);

    m92_read_mux u_read_mux (
        .req, .rom_data, .ram_data, .io_data, .rom_busy, .cpu_din, .n_ready
    );

endmodule

// ==== src/m92_io_pkg.sv ====
/*
  I/O port map and input/control bundles of the main CPU.
  Port addresses are word aligned; only the low 8 address bits decode.
*/
package m92_io_pkg;

    // ============================================================
    // Port addresses
    // ============================================================
    localparam logic [7:0] PORT_P1P2  = 8'h00;
    localparam logic [7:0] PORT_FLAGS = 8'h02;   // Read: flags, write: system control
    localparam logic [7:0] PORT_DIPS  = 8'h04;
    localparam logic [7:0] PORT_BANK  = 8'h20;

    // Player buttons are active high here, the ports invert them
    typedef struct packed {
        logic [9:0]  p1;
        logic [9:0]  p2;
        logic [1:0]  coin;
        logic [1:0]  start;
        logic [23:0] dip_sw;
    } player_in_t;

    // Bit 0 of the flag byte is coin_lock0, bit 5 is bank_hi
    typedef struct packed {
        logic bank_hi;
        logic brq_n;
        logic cblk;
        logic soft_flip_n;
        logic coin_lock1;
        logic coin_lock0;
    } sys_ctrl_t;

endpackage

// ==== src/m92_io_regs.sv ====
/*
  System flag, ROM bank and video control registers, and the input ports.
  Writes land on every clock of a matching write cycle.
  Port reads are combinational; unused ports read as all ones.
*/
`timescale 1ns/10ps

module m92_io_regs
    import m92_bus_pkg::*;
    import m92_io_pkg::*;
(
    input  logic        clk_sys,
    input  logic        reset_n,
    input  bus_req_t    req,
    input  logic [15:0] cpu_dout,
    input  player_in_t  players,
    input  logic        kick_harness,
    output logic [15:0] io_data,
    output sys_ctrl_t   sys_ctrl,
    output logic [3:0]  bank,
    output logic        flip,
    output logic [15:0] vid_ctrl
);

    logic [7:0] port;
    logic [7:0] p1_byte;
    logic [7:0] p2_byte;

    // Bit 6 is the kick button, only wired on the kick harness
    function automatic logic [7:0] player_byte(input logic [9:0] p, input logic kick);
        return {p[4], p[5], p[6] & kick, 1'b0, p[3], p[2], p[1], p[0]};
    endfunction

    assign port    = {req.addr[7:1], 1'b0};
    assign p1_byte = player_byte(players.p1, kick_harness);
    assign p2_byte = player_byte(players.p2, kick_harness);

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            sys_ctrl <= '0;
            bank     <= 4'h0;
            vid_ctrl <= 16'h0000;
        end else begin
            if (req.cycle == cyc_io_write && port == PORT_FLAGS) begin
                sys_ctrl <= sys_ctrl_t'(cpu_dout[5:0]);
            end
            if (req.cycle == cyc_io_write && port == PORT_BANK) begin
                bank <= cpu_dout[3:0];
            end
            if (req.cycle == cyc_mem_write && req.region == rgn_video_ctrl) begin
                vid_ctrl <= cpu_dout;
            end
        end
    end

    // Flag bit 2 drives the soft flip line inverted, as on the board
    assign flip = ~sys_ctrl.soft_flip_n ^ ~players.dip_sw[8];

    always_comb begin
        case (port)
            PORT_P1P2:  io_data = {~p2_byte, ~p1_byte};
            PORT_FLAGS: io_data = {~players.dip_sw[23:16], 4'hF, ~players.coin, ~players.start};
            PORT_DIPS:  io_data = ~players.dip_sw[15:0];
            default:    io_data = 16'hFFFF;
        endcase
    end

endmodule

// ==== src/m92_read_mux.sv ====
/*
  CPU read data select and ready line.
  Anything not decoded returns 0xFFFF, like an undriven bus.
*/
`timescale 1ns/10ps

module m92_read_mux
    import m92_bus_pkg::*;
(
    input  bus_req_t    req,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] io_data,
    input  logic        rom_busy,
    output logic [15:0] cpu_din,
    output logic        n_ready
);

    always_comb begin
        case (req.cycle)
            cyc_io_read: cpu_din = io_data;
            cyc_mem_read: begin
                case (req.region)
                    rgn_rom_fixed, rgn_rom_banked: cpu_din = rom_data;
                    rgn_work_ram:                  cpu_din = ram_data;
                    default:                       cpu_din = 16'hFFFF;
                endcase
            end
            default: cpu_din = 16'hFFFF;
        endcase
    end

    // Only ROM fetches stretch the cycle
    assign n_ready = rom_busy;

endmodule

// ==== src/m92_rom_fetch.sv ====
/*
  Program ROM word fetch over the AXI4-Lite read channels.
  One read in flight at a time; busy holds the CPU until the word is latched.
  Read responses are not checked, rresp has no effect.
*/
`timescale 1ns/10ps

module m92_rom_fetch
    import m92_bus_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  reset_n,
    input  logic                  rom_start,
    input  bus_req_t              req,
    output logic [ROM_ADDR_W-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [15:0]           rdata,
    input  logic [1:0]            rresp,
    input  logic                  rvalid,
    output logic                  rready,
    output logic [15:0]           rom_data,
    output logic                  busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data
    } fetch_state_e;

    fetch_state_e state;

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state   <= st_idle;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (state)
                st_idle: if (rom_start) begin
                    arvalid <= 1'b1;
                    state   <= st_addr;
                end
                st_addr: if (arready) begin    // AR handshake
                    arvalid <= 1'b0;
                    rready  <= 1'b1;
                    state   <= st_data;
                end
                st_data: if (rvalid) begin     // R handshake
                    rready <= 1'b0;
                    state  <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Address and data capture
    always_ff @(posedge clk_sys) begin
        if (state == st_idle && rom_start) araddr <= req.rom_addr;
        if (state == st_data && rvalid) rom_data <= rdata;
    end

    assign busy = (state != st_idle);

endmodule

// ==== src/m92_work_ram.sv ====
/*
  64 KiB work RAM as 32K x 16 with per-byte write enables.
  Reads are asynchronous; contents are undefined after power up.
*/
`timescale 1ns/10ps

module m92_work_ram
    import m92_bus_pkg::*;
(
    input  logic        clk_sys,
    input  bus_req_t    req,
    input  logic [15:0] cpu_dout,
    output logic [15:0] ram_data
);

    logic [15:0] mem [0:32767];
    logic [14:0] idx;
    logic        wr;

    assign idx = req.addr[15:1];
    assign wr  = (req.cycle == cyc_mem_write) && (req.region == rgn_work_ram);

    always_ff @(posedge clk_sys) begin
        if (wr && req.lanes[1]) mem[idx][15:8] <= cpu_dout[15:8];
        if (wr && req.lanes[0]) mem[idx][7:0] <= cpu_dout[7:0];
    end

    assign ram_data = mem[idx];

endmodule

// ==== verif/m92_tb_tests.svh ====
/*
  Directed tests for the bus controller testbench.
  Included inside the testbench module, uses its signals and helper tasks.
*/
`ifndef M92_TB_TESTS_SVH
`define M92_TB_TESTS_SVH

task automatic reset_defaults();
    player_in_t pl;
    logic       exp_flip;
    begin_test("reset_defaults");
    pl = random_players();
    @(posedge clk_sys);
    players <= pl;
    @(negedge clk_sys);
    exp_flip = 1'b1 ^ ~pl.dip_sw[8];   // soft_flip_n is 0 after reset
    check("sys_ctrl", 32'(0), {26'h0, sys_ctrl});
    check("vid_ctrl", 32'(0), 32'(vid_ctrl));
    check("flip", 32'(exp_flip), 32'(flip));
    check("n_ready", 32'(0), 32'(n_ready));
    check("arvalid", 32'(0), 32'(arvalid));
    end_test();
endtask

task automatic io_port_reads();
    player_in_t  pl;
    logic        kick;
    logic [15:0] rd;
    logic [15:0] exp_d;
    int          i;
    begin_test("io_port_reads");
    for (i = 0; i < 6; i++) begin
        kick = i[0];
        pl   = random_players();
        @(posedge clk_sys);
        players      <= pl;
        kick_harness <= kick;
        io_read(PORT_P1P2, rd);
        exp_d = {~player_bits(pl.p2, kick), ~player_bits(pl.p1, kick)};
        check("port 0x00", 32'(exp_d), 32'(rd));
        io_read(PORT_FLAGS, rd);
        exp_d = {~pl.dip_sw[23:16], 4'hF, ~pl.coin, ~pl.start};
        check("port 0x02", 32'(exp_d), 32'(rd));
        io_read(PORT_DIPS, rd);
        exp_d = ~pl.dip_sw[15:0];
        check("port 0x04", 32'(exp_d), 32'(rd));
    end
    io_read(8'h06, rd);
    check("port 0x06", 32'h0000FFFF, 32'(rd));
    io_read(8'h08, rd);
    check("port 0x08", 32'h0000FFFF, 32'(rd));
    end_test();
endtask

task automatic rom_read_check(input logic [19:0] addr, input logic [ROM_ADDR_W-1:0] exp_ar);
    logic [15:0] rd;
    logic [15:0] exp_d;
    int          waits;
    exp_d = exp_ar[15:0] ^ 16'hA5A5;
    mem_read(addr, rd, waits);
    check("araddr", 32'(exp_ar), 32'(ar_seen));
    check("rom data", 32'(exp_d), 32'(rd));
    check("rom wait", 32'(1), 32'(waits > 0));
endtask

task automatic io_reg_writes();
    player_in_t  pl;
    logic [15:0] data;
    logic [5:0]  exp_ctrl;
    logic        exp_flip;
    int          i;
    begin_test("io_reg_writes");
    for (i = 0; i < 4; i++) begin
        pl   = random_players();
        data = 16'($random(seed));
        @(posedge clk_sys);
        players <= pl;
        io_write(PORT_FLAGS, data);
        @(negedge clk_sys);
        exp_ctrl = data[5:0];
        exp_flip = ~data[2] ^ ~pl.dip_sw[8];   // Flag bit 2 is soft_flip_n
        check("sys_ctrl", 32'(exp_ctrl), {26'h0, sys_ctrl});
        check("flip", 32'(exp_flip), 32'(flip));
        data = 16'($random(seed));
        mem_write(VID_CTRL_ADDR, data, 1'b0);
        @(negedge clk_sys);
        check("vid_ctrl", 32'(data), 32'(vid_ctrl));
    end
    // Bank register is only visible through the translated ROM address
    io_write(PORT_BANK, 16'h0007);
    rom_read_check(ROM_BANK_BASE | 20'h01234, ROM_BANK_OFFSET + 24'h070000 + 24'h001234);
    end_test();
endtask

task automatic work_ram_rw();
    logic [19:0] addr;
    logic [15:0] word;
    logic [15:0] rd;
    logic [7:0]  hb;
    logic [7:0]  lb;
    int          waits;
    int          i;
    begin_test("work_ram_rw");
    for (i = 0; i < 6; i++) begin
        addr = RAM_BASE | {4'h0, 15'($random(seed)), 1'b0};
        word = 16'($random(seed));
        hb   = 8'($random(seed));
        lb   = 8'($random(seed));
        mem_write(addr, word, 1'b0);
        mem_read(addr, rd, waits);
        check("ram word", 32'(word), 32'(rd));
        mem_write(addr | 20'h00001, {hb, ~word[7:0]}, 1'b0);   // Odd byte, high lane
        mem_read(addr, rd, waits);
        check("ram high byte", 32'({hb, word[7:0]}), 32'(rd));
        mem_write(addr, {~hb, lb}, 1'b1);                      // Even byte, low lane
        mem_read(addr, rd, waits);
        check("ram low byte", 32'({hb, lb}), 32'(rd));
        check("ram wait", 32'(0), 32'(waits));
    end
    end_test();
endtask

task automatic rom_reads();
    logic [19:0] addr;
    logic [3:0]  bnk;
    int          i;
    begin_test("rom_reads");
    for (i = 0; i < 6; i++) begin
        addr = 20'($unsigned($random(seed)) % 32'h000A0000);
        rom_read_check(addr, {4'h0, addr[19:1], 1'b0});
    end
    for (i = 0; i < 6; i++) begin
        bnk  = 4'($random(seed));
        addr = ROM_BANK_BASE | {4'h0, 16'($random(seed))};
        io_write(PORT_BANK, {12'h000, bnk});
        rom_read_check(addr, ROM_BANK_OFFSET + 24'(bnk) * 24'h010000
                             + {8'h00, addr[15:1], 1'b0});
    end
    end_test();
endtask

task automatic unmapped_read();
    logic [19:0] addrs [0:2];
    logic [15:0] rd;
    int          waits;
    int          i;
    begin_test("unmapped_read");
    addrs = '{20'hC0000, 20'hB1234, 20'hF9802};
    for (i = 0; i < 3; i++) begin
        mem_read(addrs[i], rd, waits);
        check("open bus data", 32'h0000FFFF, 32'(rd));
        check("open bus wait", 32'(0), 32'(waits));
    end
    end_test();
endtask

`endif

// ==== verif/m92_tb.sv ====
/*
  Testbench for the main CPU bus controller. The main process plays the V33 core,
  a second process answers AXI4-Lite ROM reads with 0 to 3 cycles of delay.
  Outputs are sampled on the falling clock edge, inputs change on the rising edge.
*/
`timescale 1ns/10ps

module m92_tb
    import m92_bus_pkg::*;
    import m92_io_pkg::*;
();

    // About 80 bus cycles of at most 12 clocks each is under 4 us
    localparam int WATCHDOG_NS = 20_000;

    logic                  clk_sys;
    logic                  reset_n;
    cpu_status_t           status;
    logic [15:0]           cpu_dout;
    logic [15:0]           cpu_din;
    logic                  n_ready;
    player_in_t            players;
    logic                  kick_harness;
    logic [ROM_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [15:0]           rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    sys_ctrl_t             sys_ctrl;
    logic                  flip;
    logic [15:0]           vid_ctrl;

    integer                seed = 34;
    int                    error_count = 0;
    int                    test_errors = 0;
    int                    tests_run = 0;
    int                    tests_failed = 0;
    string                 current_test = "";
    logic [ROM_ADDR_W-1:0] ar_seen;          // Last address taken by the responder

    m92_cpu_bus dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic cpu_status_t idle_status();
        cpu_status_t s;
        s         = '0;
        s.busst0  = 1'b1;
        s.busst1  = 1'b1;   // Passive state, decodes as idle
        s.n_dstb  = 1'b1;
        s.n_bcyst = 1'b1;
        s.n_ube   = 1'b1;
        return s;
    endfunction

    task automatic check(input string label, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s (%s): expected 0x%0h, actual 0x%0h",
                     current_test, label, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_errors  = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("Test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", current_test, test_errors);
        end
    endtask

    // One V33 bus cycle; waits counts the clocks spent with n_ready high
    task automatic bus_cycle(input logic m_io, input logic r_w, input logic [19:0] addr,
                             input logic n_ube, input logic [15:0] wdata,
                             output logic [15:0] rd, output int waits);
        cpu_status_t s;
        s         = idle_status();
        s.m_io    = m_io;
        s.r_w     = r_w;
        s.busst0  = 1'b1;
        s.busst1  = 1'b0;
        s.n_dstb  = 1'b0;
        s.n_bcyst = 1'b0;
        s.n_ube   = n_ube;
        s.addr    = addr;
        waits     = 0;
        @(posedge clk_sys);
        status   <= s;
        cpu_dout <= wdata;
        @(posedge clk_sys);
        status.n_bcyst <= 1'b1;   // Bus cycle start lasts one clock
        @(negedge clk_sys);
        while (n_ready) begin
            waits++;
            @(negedge clk_sys);
        end
        rd = cpu_din;
        @(posedge clk_sys);
        status <= idle_status();
    endtask

    task automatic io_write(input logic [7:0] port, input logic [15:0] data);
        logic [15:0] rd;
        int          waits;
        bus_cycle(1'b0, 1'b0, {12'h000, port}, 1'b0, data, rd, waits);
    endtask

    task automatic io_read(input logic [7:0] port, output logic [15:0] rd);
        int waits;
        bus_cycle(1'b0, 1'b1, {12'h000, port}, 1'b0, 16'h0000, rd, waits);
    endtask

    task automatic mem_write(input logic [19:0] addr, input logic [15:0] data,
                             input logic n_ube);
        logic [15:0] rd;
        int          waits;
        bus_cycle(1'b1, 1'b0, addr, n_ube, data, rd, waits);
    endtask

    task automatic mem_read(input logic [19:0] addr, output logic [15:0] rd,
                            output int waits);
        bus_cycle(1'b1, 1'b1, addr, 1'b0, 16'h0000, rd, waits);
    endtask

    function automatic player_in_t random_players();
        logic [63:0] rnd;
        rnd = {$random(seed), $random(seed)};
        return player_in_t'(rnd[47:0]);
    endfunction

    // Board wiring of one player byte, bit 7 down to bit 0
    function automatic logic [7:0] player_bits(input logic [9:0] p, input logic kick);
        logic [7:0] b;
        b      = 8'h00;
        b[7]   = p[4];
        b[6]   = p[5];
        b[5]   = kick & p[6];
        b[3:0] = p[3:0];
        return b;
    endfunction

    `include "m92_tb_tests.svh"

    // ============================================================
    // AXI4-Lite read responder, data is the address xor 0xA5A5
    // ============================================================
    initial begin : axi_responder
        int                    delay;
        int                    i;
        logic [ROM_ADDR_W-1:0] addr_q;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = 16'h0000;
        forever begin
            @(posedge clk_sys);
            if (arvalid) begin
                addr_q  = araddr;
                ar_seen = araddr;
                delay   = $random(seed) & 3;
                for (i = 0; i < delay; i++) begin
                    @(posedge clk_sys);
                    check("ar hold", {7'h00, 1'b1, addr_q}, {7'h00, arvalid, araddr});
                end
                arready <= 1'b1;
                @(posedge clk_sys);
                arready <= 1'b0;
                delay = $random(seed) & 3;
                repeat (delay) @(posedge clk_sys);
                rdata  <= addr_q[15:0] ^ 16'hA5A5;
                rvalid <= 1'b1;
                @(posedge clk_sys);
                check("rready", 32'(1), 32'(rready));
                rvalid <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns, the DUT may hold a wait",
                 WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main_sequence
        reset_n      = 1'b0;
        status       = idle_status();
        cpu_dout     = 16'h0000;
        players      = '0;
        kick_harness = 1'b0;
        rresp        = 2'b00;
        repeat (3) @(posedge clk_sys);
        reset_n <= 1'b1;
        reset_defaults();
        io_port_reads();
        io_reg_writes();
        work_ram_rw();
        rom_reads();
        unmapped_read();
        $display("Tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
